//--- logic/conv_pkg.sv
package conv_pkg;

	// memory word address
	typedef logic [15:0] addr_t;

	// layer dimensions and loop indices
	typedef logic [5:0] row_t;
	typedef logic [8:0] chan_t;
	typedef logic [9:0] kern_t;

	// datapath values
	typedef logic signed [7:0] pix_t;
	typedef logic signed [7:0] wt_t;
	typedef logic signed [15:0] prod_t;
	typedef logic signed [15:0] acc_t;

	// four signed codebook bytes picked by a 2-bit index
	typedef logic [1:0] wt_idx_t;
	typedef logic [31:0] codebook_t;

	// one request on a single-port memory
	typedef struct packed {
		logic cs;
		logic we;
		addr_t addr;
		logic [31:0] wdata;
	} ram_req_t;

	typedef enum logic [2:0] {
		idle,
		ld_parm,
		ld_bias,
		ld_wt,
		ld_in,
		calc,
		st_out,
		fin
	} seq_state_t;

	// which rule the reducer applies to a channel group
	typedef enum logic [1:0] {
		first,
		middle,
		last
	} group_kind_t;

endpackage

//--- logic/conv_lane.sv
`timescale 1ns/1ps

module conv_lane (
	input logic clk,
	input logic rst,
	input logic load,
	input conv_pkg::pix_t pix,
	input logic wt_load,
	input conv_pkg::wt_idx_t wt_idx,
	input conv_pkg::codebook_t codebook,
	input logic mul_en,
	output conv_pkg::prod_t prod
);

	conv_pkg::pix_t pix_q;
	conv_pkg::wt_t wt_q;
	conv_pkg::wt_t wt_dec;

	// index picks one byte of the codebook
	always_comb begin
		wt_dec = conv_pkg::wt_t'(codebook[{wt_idx, 3'b000} +: 8]);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_q <= '0;
			wt_q <= '0;
			prod <= '0;
		end else begin
			if (load) begin
				pix_q <= pix;
			end
			if (wt_load) begin
				wt_q <= wt_dec;
			end
			// signed 8x8 product fits in 16 bits
			if (mul_en) begin
				prod <= pix_q * wt_q;
			end
		end
	end

endmodule

//--- logic/conv_reducer.sv
`timescale 1ns/1ps

module conv_reducer #(
	parameter int LANES = 9
) (
	input logic clk,
	input logic rst,
	input logic sum_en,
	input conv_pkg::group_kind_t kind,
	input conv_pkg::prod_t [LANES-1:0] prods,
	input conv_pkg::acc_t bias,
	input conv_pkg::acc_t partial,
	output conv_pkg::acc_t result
);

	conv_pkg::acc_t total;
	conv_pkg::acc_t sum;
	conv_pkg::acc_t next_result;

	// adder tree over all lanes that wraps at 16 bits
	always_comb begin
		total = '0;
		for (int i = 0; i < LANES; i++) begin
			total = total + prods[i];
		end
	end

	// first group starts from the bias, later groups from the stored partial
	assign sum = total + ((kind == conv_pkg::first) ? bias : partial);

	// re-quantize to an unsigned byte on the last group
	always_comb begin
		if (kind != conv_pkg::last) begin
			next_result = sum;
		end else if (sum[15]) begin
			next_result = '0;
		end else if (|sum[15:12]) begin
			next_result = 16'h007f;
		end else begin
			next_result = {8'h00, sum[12:5]};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result <= '0;
		end else if (sum_en) begin
			result <= next_result;
		end
	end

endmodule

//--- logic/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer #(
	parameter int LANES = 9
) (
	input logic clk,
	input logic rst,
	input logic start,
	input conv_pkg::codebook_t codebook_in,
	input logic [31:0] param_rdata,
	input logic [31:0] bias_rdata,
	input logic [31:0] weight_rdata,
	input logic [31:0] input_rdata,
	input logic [31:0] output_rdata,
	input conv_pkg::acc_t sum_result,
	output conv_pkg::ram_req_t param_req,
	output conv_pkg::ram_req_t bias_req,
	output conv_pkg::ram_req_t weight_req,
	output conv_pkg::ram_req_t input_req,
	output conv_pkg::ram_req_t output_req,
	output conv_pkg::codebook_t codebook,
	output logic lane_load,
	output logic wt_load,
	output logic mul_en,
	output logic sum_en,
	output conv_pkg::chan_t lane_sel,
	output conv_pkg::pix_t lane_pix,
	output logic [2*LANES-1:0] wt_word,
	output conv_pkg::group_kind_t group_kind,
	output logic finish
);

	conv_pkg::seq_state_t state;
	conv_pkg::seq_state_t nxt;
	conv_pkg::chan_t cnt;
	logic last_step;

	// layer parameters
	conv_pkg::row_t rows;
	conv_pkg::chan_t chans;
	conv_pkg::kern_t kerns;

	// loop position
	conv_pkg::kern_t k_idx;
	conv_pkg::chan_t ch_base;
	conv_pkg::addr_t pos;
	conv_pkg::addr_t wt_addr;
	conv_pkg::addr_t out_addr;
	conv_pkg::addr_t in_addr;

	conv_pkg::addr_t plane;
	conv_pkg::addr_t in_start;
	conv_pkg::addr_t in_cur;
	conv_pkg::chan_t rem;
	conv_pkg::chan_t grp_n;
	logic have_rem;
	logic more;
	logic sweep_end;

	assign plane = conv_pkg::addr_t'(rows) * conv_pkg::addr_t'(rows);
	assign sweep_end = (pos == plane - conv_pkg::addr_t'(1));

	// channels left from this group on; a group past the end is empty
	assign have_rem = (ch_base < chans);
	assign rem = chans - ch_base;
	assign more = have_rem && (rem > conv_pkg::chan_t'(LANES));
	assign grp_n = !have_rem ? '0 : (more ? conv_pkg::chan_t'(LANES) : rem);

	// a single-group layer gets an empty last group for the re-quantize pass
	always_comb begin
		if (ch_base == '0) begin
			group_kind = conv_pkg::first;
		end else if (!more) begin
			group_kind = conv_pkg::last;
		end else begin
			group_kind = conv_pkg::middle;
		end
	end

	// inputs are fetched from the top channel of the group downwards
	assign in_start = conv_pkg::addr_t'(ch_base + grp_n - conv_pkg::chan_t'(1)) * plane + pos;
	assign in_cur = (cnt == '0) ? in_start : in_addr;
	assign wt_word = weight_rdata[2*LANES-1:0];

	always_comb begin
		case (state)
			conv_pkg::idle: last_step = start;
			conv_pkg::ld_parm: last_step = (cnt == conv_pkg::chan_t'(3));
			conv_pkg::ld_in: last_step = (cnt == grp_n);
			conv_pkg::st_out: last_step = (cnt == conv_pkg::chan_t'(2));
			conv_pkg::fin: last_step = 1'b1;
			default: last_step = (cnt == conv_pkg::chan_t'(1));
		endcase
	end

	always_comb begin
		case (state)
			conv_pkg::idle: nxt = conv_pkg::ld_parm;
			conv_pkg::ld_parm: nxt = conv_pkg::ld_bias;
			conv_pkg::ld_bias: nxt = conv_pkg::ld_wt;
			conv_pkg::ld_wt: nxt = conv_pkg::ld_in;
			conv_pkg::ld_in: nxt = conv_pkg::calc;
			conv_pkg::calc: nxt = conv_pkg::st_out;
			conv_pkg::st_out: begin
				if (!sweep_end) begin
					nxt = conv_pkg::ld_in;
				end else if (group_kind != conv_pkg::last) begin
					// the empty group needs no weight word
					nxt = more ? conv_pkg::ld_wt : conv_pkg::ld_in;
				end else if (k_idx == kerns - conv_pkg::kern_t'(1)) begin
					nxt = conv_pkg::fin;
				end else begin
					nxt = conv_pkg::ld_bias;
				end
			end
			default: nxt = conv_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= conv_pkg::idle;
			cnt <= '0;
			codebook <= '0;
			rows <= '0;
			chans <= '0;
			kerns <= '0;
			k_idx <= '0;
			ch_base <= '0;
			pos <= '0;
			wt_addr <= '0;
			out_addr <= '0;
			in_addr <= '0;
		end else begin
			if (last_step) begin
				state <= nxt;
				cnt <= '0;
			end else begin
				cnt <= cnt + conv_pkg::chan_t'(1);
			end
			case (state)
				conv_pkg::idle: begin
					if (start) begin
						codebook <= codebook_in;
						k_idx <= '0;
						ch_base <= '0;
						pos <= '0;
						wt_addr <= '0;
						out_addr <= '0;
					end
				end
				conv_pkg::ld_parm: begin
					case (cnt)
						conv_pkg::chan_t'(1): rows <= param_rdata[5:0];
						conv_pkg::chan_t'(2): chans <= param_rdata[8:0];
						conv_pkg::chan_t'(3): kerns <= param_rdata[9:0];
						default: ;
					endcase
				end
				conv_pkg::ld_wt: begin
					if (cnt == conv_pkg::chan_t'(1)) begin
						wt_addr <= wt_addr + conv_pkg::addr_t'(1);
					end
				end
				conv_pkg::ld_in: in_addr <= in_cur - plane;
				conv_pkg::st_out: begin
					if (cnt == conv_pkg::chan_t'(2)) begin
						if (!sweep_end) begin
							pos <= pos + conv_pkg::addr_t'(1);
							out_addr <= out_addr + conv_pkg::addr_t'(1);
						end else if (group_kind != conv_pkg::last) begin
							// back to the start of this kernel's region
							pos <= '0;
							out_addr <= out_addr + conv_pkg::addr_t'(1) - plane;
							ch_base <= ch_base + conv_pkg::chan_t'(LANES);
						end else begin
							pos <= '0;
							out_addr <= out_addr + conv_pkg::addr_t'(1);
							ch_base <= '0;
							k_idx <= k_idx + conv_pkg::kern_t'(1);
						end
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		param_req = '0;
		bias_req = '0;
		weight_req = '0;
		input_req = '0;
		output_req = '0;
		lane_load = 1'b0;
		lane_sel = '0;
		lane_pix = '0;
		wt_load = 1'b0;
		mul_en = 1'b0;
		sum_en = 1'b0;
		finish = 1'b0;
		case (state)
			conv_pkg::ld_parm: begin
				param_req.cs = (cnt < conv_pkg::chan_t'(3));
				param_req.addr = conv_pkg::addr_t'(cnt);
			end
			conv_pkg::ld_bias: begin
				bias_req.cs = (cnt == '0);
				bias_req.addr = conv_pkg::addr_t'(k_idx);
			end
			conv_pkg::ld_wt: begin
				weight_req.cs = (cnt == '0);
				weight_req.addr = wt_addr;
				wt_load = (cnt == conv_pkg::chan_t'(1));
			end
			conv_pkg::ld_in: begin
				input_req.cs = (cnt < grp_n);
				input_req.addr = in_cur;
				lane_load = 1'b1;
				if (cnt == '0) begin
					// zero every lane before the real pixels arrive
					lane_sel = conv_pkg::chan_t'(LANES - 1);
				end else begin
					lane_sel = grp_n - cnt;
					lane_pix = conv_pkg::pix_t'(input_rdata[7:0]);
				end
			end
			conv_pkg::calc: begin
				if (cnt == '0) begin
					mul_en = 1'b1;
					// addend for the reducer arrives with sum_en
					if (group_kind == conv_pkg::first) begin
						bias_req.cs = 1'b1;
						bias_req.addr = conv_pkg::addr_t'(k_idx);
					end else begin
						output_req.cs = 1'b1;
						output_req.addr = out_addr;
					end
				end else begin
					sum_en = 1'b1;
				end
			end
			conv_pkg::st_out: begin
				if (cnt == conv_pkg::chan_t'(2)) begin
					output_req.cs = 1'b1;
					output_req.we = 1'b1;
					output_req.addr = out_addr;
					output_req.wdata = {16'h0000, sum_result};
				end
			end
			conv_pkg::fin: finish = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- logic/conv1x1_top.sv
`timescale 1ns/1ps

module conv1x1_top #(
	parameter int LANES = 9
) (
	input logic clk,
	input logic rst,
	input logic start,
	input conv_pkg::codebook_t codebook_in,
	input logic [31:0] param_rdata,
	input logic [31:0] bias_rdata,
	input logic [31:0] weight_rdata,
	input logic [31:0] input_rdata,
	input logic [31:0] output_rdata,
	output conv_pkg::ram_req_t param_req,
	output conv_pkg::ram_req_t bias_req,
	output conv_pkg::ram_req_t weight_req,
	output conv_pkg::ram_req_t input_req,
	output conv_pkg::ram_req_t output_req,
	output logic finish
);

	conv_pkg::codebook_t codebook;
	logic lane_load;
	logic wt_load;
	logic mul_en;
	logic sum_en;
	conv_pkg::chan_t lane_sel;
	conv_pkg::pix_t lane_pix;
	logic [2*LANES-1:0] wt_word;
	conv_pkg::group_kind_t group_kind;
	conv_pkg::acc_t sum_result;
	conv_pkg::prod_t [LANES-1:0] prods;

	conv_sequencer #(
		.LANES(LANES)
	) u_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.codebook_in(codebook_in),
		.param_rdata(param_rdata),
		.bias_rdata(bias_rdata),
		.weight_rdata(weight_rdata),
		.input_rdata(input_rdata),
		.output_rdata(output_rdata),
		.sum_result(sum_result),
		.param_req(param_req),
		.bias_req(bias_req),
		.weight_req(weight_req),
		.input_req(input_req),
		.output_req(output_req),
		.codebook(codebook),
		.lane_load(lane_load),
		.wt_load(wt_load),
		.mul_en(mul_en),
		.sum_en(sum_en),
		.lane_sel(lane_sel),
		.lane_pix(lane_pix),
		.wt_word(wt_word),
		.group_kind(group_kind),
		.finish(finish)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic load;

		// lanes at or below lane_sel capture; descending loads leave each lane its own pixel
		assign load = lane_load && (conv_pkg::chan_t'(i) <= lane_sel);

		conv_lane u_lane (
			.clk(clk),
			.rst(rst),
			.load(load),
			.pix(lane_pix),
			.wt_load(wt_load),
			.wt_idx(wt_word[2*i +: 2]),
			.codebook(codebook),
			.mul_en(mul_en),
			.prod(prods[i])
		);
	end

	conv_reducer #(
		.LANES(LANES)
	) u_reducer (
		.clk(clk),
		.rst(rst),
		.sum_en(sum_en),
		.kind(group_kind),
		.prods(prods),
		.bias(conv_pkg::acc_t'(bias_rdata[15:0])),
		.partial(conv_pkg::acc_t'(output_rdata[15:0])),
		.result(sum_result)
	);

endmodule

//--- sim/conv1x1_asserts.sv
`timescale 1ns/1ps

module conv1x1_asserts (
	input logic clk,
	input logic rst,
	input conv_pkg::seq_state_t state,
	input logic finish,
	input logic param_cs,
	input logic bias_cs,
	input logic weight_cs,
	input logic input_cs,
	input logic output_cs,
	input logic output_we
);

	// failed assertions so far
	int fail_count;

	finish_pulse: assert property (@(posedge clk) disable iff (!rst) finish |=> !finish)
		else begin
			$error("finish stayed high for more than one cycle");
			fail_count++;
		end

	// single memory access per cycle
	one_cs: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({param_cs, bias_cs, weight_cs, input_cs, output_cs}))
		else begin
			$error("more than one memory selected in the same cycle");
			fail_count++;
		end

	we_needs_cs: assert property (@(posedge clk) disable iff (!rst) output_we |-> output_cs)
		else begin
			$error("output write enable without chip select");
			fail_count++;
		end

	param_in_load: assert property (@(posedge clk) disable iff (!rst)
		param_cs |-> (state == conv_pkg::ld_parm || state == conv_pkg::idle))
		else begin
			$error("parameter memory selected outside the parameter load");
			fail_count++;
		end

endmodule

//--- sim/conv1x1_checker.sv
`timescale 1ns/1ps

module conv1x1_checker #(
	parameter int LANES = 9,
	parameter int DEPTH = 1024
) (
	input logic clk,
	input logic rst,
	input conv_pkg::ram_req_t output_req,
	input logic finish,
	input conv_pkg::row_t rows,
	input conv_pkg::chan_t chans,
	input conv_pkg::kern_t kerns,
	input conv_pkg::codebook_t codebook,
	input logic [31:0] bias_mem [DEPTH],
	input logic [31:0] weight_mem [DEPTH],
	input logic [31:0] input_mem [DEPTH],
	output int runs,
	output int errors
);

	conv_pkg::acc_t seen [DEPTH];
	bit written [DEPTH];

	// bias plus every channel product, then re-quantize
	function automatic conv_pkg::acc_t expected_value(input int k, input int p);
		int plane;
		int groups;
		int sum;
		conv_pkg::wt_idx_t idx;
		conv_pkg::wt_t w;
		conv_pkg::pix_t x;
		conv_pkg::acc_t acc;
		plane = rows * rows;
		groups = (chans + LANES - 1) / LANES;
		acc = bias_mem[k][15:0];
		sum = acc;
		for (int c = 0; c < chans; c++) begin
			idx = weight_mem[k * groups + c / LANES][2 * (c % LANES) +: 2];
			w = codebook[8 * idx +: 8];
			x = input_mem[c * plane + p][7:0];
			sum = sum + int'(x) * int'(w);
		end
		// wraps to 16 bits like the output memory
		acc = sum[15:0];
		if (acc < 0) begin
			return '0;
		end else if (acc[15:12] != 4'h0) begin
			return 16'h007f;
		end
		return {8'h00, acc[12:5]};
	endfunction

	task automatic compare_map();
		int plane;
		int bad;
		int a;
		conv_pkg::acc_t exp_val;
		plane = rows * rows;
		bad = 0;
		for (int k = 0; k < kerns; k++) begin
			for (int p = 0; p < plane; p++) begin
				a = k * plane + p;
				exp_val = expected_value(k, p);
				if (!written[a]) begin
					$display("case %0d: kernel %0d position %0d was never written", runs, k, p);
					bad++;
				end else if (seen[a] !== exp_val) begin
					$display("Fail at %0t: case %0d kernel %0d position %0d got %h expected %h",
						$time, runs, k, p, seen[a], exp_val);
					bad++;
				end
			end
		end
		$display("case %0d: %0d outputs checked, %0d mismatches", runs, kerns * plane, bad);
		errors += bad;
		runs++;
		for (int i = 0; i < DEPTH; i++) begin
			written[i] = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		if (rst && output_req.cs && output_req.we) begin
			if (int'(output_req.addr) >= int'(kerns) * int'(rows) * int'(rows)) begin
				$display("Fail at %0t: case %0d write to %0d lies outside the output map",
					$time, runs, output_req.addr);
				errors++;
			end else if (int'(output_req.addr) < DEPTH) begin
				seen[output_req.addr] = output_req.wdata[15:0];
				written[output_req.addr] = 1'b1;
			end
		end
		// last write landed one cycle before finish
		if (rst && finish) begin
			compare_map();
		end
	end

endmodule

//--- sim/conv1x1_tb.sv
`timescale 1ns/1ps

module conv1x1_tb;

	localparam int LANES = 9;
	localparam int DEPTH = 1024;
	localparam int NTESTS = 7;

	// dimensions, codebook and pixel style of one layer
	typedef struct packed {
		conv_pkg::row_t rows;
		conv_pkg::chan_t chans;
		conv_pkg::kern_t kerns;
		conv_pkg::codebook_t codebook;
		logic extreme;
	} test_case_t;

	logic clk;
	logic rst;
	logic start;
	conv_pkg::codebook_t codebook_in;
	logic [31:0] param_rdata;
	logic [31:0] bias_rdata;
	logic [31:0] weight_rdata;
	logic [31:0] input_rdata;
	logic [31:0] output_rdata;
	conv_pkg::ram_req_t param_req;
	conv_pkg::ram_req_t bias_req;
	conv_pkg::ram_req_t weight_req;
	conv_pkg::ram_req_t input_req;
	conv_pkg::ram_req_t output_req;
	logic finish;

	logic [31:0] param_mem [DEPTH];
	logic [31:0] bias_mem [DEPTH];
	logic [31:0] weight_mem [DEPTH];
	logic [31:0] input_mem [DEPTH];
	logic [31:0] output_mem [DEPTH];
	logic [4:0] rd_q;
	conv_pkg::addr_t rd_addr [5];

	test_case_t tests [NTESTS];
	test_case_t cur;
	int runs;
	int errors;
	int cycles;
	int cycle_limit;

	conv1x1_top #(
		.LANES(LANES)
	) u_conv1x1_top (
		.clk(clk),
		.rst(rst),
		.start(start),
		.codebook_in(codebook_in),
		.param_rdata(param_rdata),
		.bias_rdata(bias_rdata),
		.weight_rdata(weight_rdata),
		.input_rdata(input_rdata),
		.output_rdata(output_rdata),
		.param_req(param_req),
		.bias_req(bias_req),
		.weight_req(weight_req),
		.input_req(input_req),
		.output_req(output_req),
		.finish(finish)
	);

	conv1x1_checker #(
		.LANES(LANES),
		.DEPTH(DEPTH)
	) u_checker (
		.clk(clk),
		.rst(rst),
		.output_req(output_req),
		.finish(finish),
		.rows(cur.rows),
		.chans(cur.chans),
		.kerns(cur.kerns),
		.codebook(cur.codebook),
		.bias_mem(bias_mem),
		.weight_mem(weight_mem),
		.input_mem(input_mem),
		.runs(runs),
		.errors(errors)
	);

	bind conv_sequencer conv1x1_asserts u_asserts (
		.clk(clk),
		.rst(rst),
		.state(state),
		.finish(finish),
		.param_cs(param_req.cs),
		.bias_cs(bias_req.cs),
		.weight_cs(weight_req.cs),
		.input_cs(input_req.cs),
		.output_cs(output_req.cs),
		.output_we(output_req.we)
	);

	always #5 clk = ~clk;

	// memories latch the request on the rising edge
	always @(posedge clk) begin
		rd_q <= {output_req.cs & ~output_req.we, input_req.cs & ~input_req.we,
			weight_req.cs & ~weight_req.we, bias_req.cs & ~bias_req.we,
			param_req.cs & ~param_req.we};
		rd_addr[0] <= param_req.addr;
		rd_addr[1] <= bias_req.addr;
		rd_addr[2] <= weight_req.addr;
		rd_addr[3] <= input_req.addr;
		rd_addr[4] <= output_req.addr;
		if (output_req.cs && output_req.we) begin
			output_mem[output_req.addr] = output_req.wdata;
		end
	end

	// and answer on the falling edge of the next cycle
	always @(negedge clk) begin
		if (rd_q[0]) param_rdata = param_mem[rd_addr[0]];
		if (rd_q[1]) bias_rdata = bias_mem[rd_addr[1]];
		if (rd_q[2]) weight_rdata = weight_mem[rd_addr[2]];
		if (rd_q[3]) input_rdata = input_mem[rd_addr[3]];
		if (rd_q[4]) output_rdata = output_mem[rd_addr[4]];
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	task automatic load_table();
		// rows, channels, kernels, codebook, extreme pixels
		tests[0] = {6'd3, 9'd9, 10'd1, 32'h02ff07fd, 1'b0};
		tests[1] = {6'd2, 9'd27, 10'd1, 32'h04fa03fe, 1'b0};
		tests[2] = {6'd3, 9'd13, 10'd2, 32'h01fc06fb, 1'b0};
		tests[3] = {6'd2, 9'd20, 10'd3, 32'h807fc040, 1'b0};
		tests[4] = {6'd4, 9'd4, 10'd2, 32'hff01807f, 1'b1};
		tests[5] = {6'd5, 9'd11, 10'd1, 32'h05fb02fe, 1'b0};
		tests[6] = {6'd3, 9'd18, 10'd2, 32'h7f80017f, 1'b1};
	endtask

	function automatic int estimate_cycles(input test_case_t tc);
		int plane;
		int groups;
		int per_kernel;
		plane = tc.rows * tc.rows;
		groups = (tc.chans + LANES - 1) / LANES;
		per_kernel = 2 + 2 * groups + plane * (tc.chans + 6 * groups);
		// one group still needs a separate re-quantize pass
		if (tc.chans <= LANES) begin
			per_kernel += 6 * plane;
		end
		return 10 + tc.kerns * per_kernel;
	endfunction

	task automatic fill_memories(input test_case_t tc);
		int plane;
		plane = tc.rows * tc.rows;
		for (int a = 0; a < DEPTH; a++) begin
			param_mem[a] = $urandom;
			// only the low 16 bits carry the bias
			bias_mem[a] = {16'($urandom), 16'($urandom_range(1023) - 512)};
			weight_mem[a] = $urandom;
			input_mem[a] = $urandom;
			output_mem[a] = {a[15:0] ^ 16'h3c5a, a[15:0]};
			if (tc.extreme) begin
				input_mem[a][7:0] = ((a % plane) % 2 == 0) ? 8'h7f : 8'h80;
			end
		end
		param_mem[0] = 32'(tc.rows);
		param_mem[1] = 32'(tc.chans);
		param_mem[2] = 32'(tc.kerns);
	endtask

	initial begin
		int total;
		void'($urandom(32'ha43c));
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		codebook_in = '0;
		param_rdata = '0;
		bias_rdata = '0;
		weight_rdata = '0;
		input_rdata = '0;
		output_rdata = '0;
		cycles = 0;
		load_table();
		cur = tests[0];
		total = 0;
		for (int t = 0; t < NTESTS; t++) begin
			total += estimate_cycles(tests[t]);
		end
		cycle_limit = 2 * total + 20;
		repeat (2) @(negedge clk);
		rst = 1'b1;
		for (int t = 0; t < NTESTS; t++) begin
			@(negedge clk);
			cur = tests[t];
			fill_memories(cur);
			codebook_in = cur.codebook;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			// a codebook change after start must not reach the lanes
			codebook_in = $urandom;
			while (runs < t + 1) begin
				@(negedge clk);
			end
		end
		repeat (3) @(negedge clk);
		$display("%0d cases, %0d finish pulses, %0d mismatches, %0d assertion failures",
			NTESTS, runs, errors, u_conv1x1_top.u_sequencer.u_asserts.fail_count);
		if (errors == 0 && runs == NTESTS &&
			u_conv1x1_top.u_sequencer.u_asserts.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- compile.f
logic/conv_pkg.sv
logic/conv_lane.sv
logic/conv_reducer.sv
logic/conv_sequencer.sv
logic/conv1x1_top.sv
sim/conv1x1_asserts.sv
sim/conv1x1_checker.sv
sim/conv1x1_tb.sv
